//--- source/csi2_pkg.sv
//----------------------------------------------------------
// shared types and constants for the two-lane CSI-2 packet layer
// ECC is detect-only; payload checksum is not checked
// long packet word counts must be multiples of 4
//----------------------------------------------------------
package csi2_pkg;

    typedef logic [7:0]  byte_t;
    // byte 0 = lane 0 earlier cycle, byte 1 = lane 1 earlier,
    // byte 2 = lane 0 later cycle, byte 3 = lane 1 later
    typedef logic [31:0] word_t;
    typedef logic [5:0]  data_type_t;

    localparam byte_t      SYNC_BYTE      = 8'hB8;
    localparam data_type_t DT_FRAME_START = 6'h00;
    localparam data_type_t DT_FRAME_END   = 6'h01;
    localparam data_type_t DT_RAW8        = 6'h2A;

    // lane-to-lane skew in cycles, sets deskew depth
    localparam int MAX_SKEW = 2;
    localparam int SKEW_W   = $clog2(MAX_SKEW + 1);

    //----------------------------------------------------------
    // header word: [5:0] data type, [7:6] virtual channel (ignored)
    // [23:8] word count in bytes, [29:24] ECC, [31:30] zero
    //----------------------------------------------------------

    // hamming parity over the 24 header bits
    function automatic logic [5:0] ecc_parity(input logic [23:0] hdr);
        logic [5:0] p;
        p[0] = ^(hdr & 24'hF12CB7);
        p[1] = ^(hdr & 24'hF2555B);
        p[2] = ^(hdr & 24'h749A6D);
        p[3] = ^(hdr & 24'hB8E38E);
        p[4] = ^(hdr & 24'hDF03F0);
        p[5] = ^(hdr & 24'hEFFC00);
        return p;
    endfunction

endpackage

//--- source/csi2_stream_if.sv
//----------------------------------------------------------
// stage-to-stage stream, single-cycle valid, no back-pressure
// an item exists only in the cycle its valid is high
//----------------------------------------------------------
`timescale 1ns/10ps

interface csi2_stream_if
    import csi2_pkg::*;
#(
    parameter type payload_t = byte_t
) ();

    logic     valid;
    payload_t payload;
    // first item of a burst / final item before stop state
    logic     first;
    logic     last;

    modport source (output valid, output payload, output first, output last);
    modport sink   (input valid, input payload, input first, input last);

endinterface

//--- source/lane_sync.sv
//----------------------------------------------------------
// byte-aligned sync search on one lane; input bytes are
// already deserialized, bit alignment is not searched
//----------------------------------------------------------
`timescale 1ns/10ps

module lane_sync
    import csi2_pkg::*;
(
    input  logic          pixel_clk,
    input  logic          reset,
    input  logic          stop_state_i,
    input  byte_t         lane_byte_i,
    csi2_stream_if.source lane_o
);

    typedef enum logic [1:0] {ST_STOP, ST_SEARCH, ST_ACTIVE} state_t;

    state_t state;
    logic   valid_q;
    logic   first_q;
    logic   first_pend;
    byte_t  data_q;

    always_ff @(posedge pixel_clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= ST_SEARCH;
            valid_q    <= 1'b0;
            first_q    <= 1'b0;
            first_pend <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            first_q <= 1'b0;
            if (stop_state_i)
                state <= ST_STOP;
            else
            begin
                case (state)
                    ST_STOP, ST_SEARCH:
                    begin
                        // discard until the sync byte arms the lane
                        if (lane_byte_i == SYNC_BYTE)
                        begin
                            state      <= ST_ACTIVE;
                            first_pend <= 1'b1;
                        end
                        else
                            state <= ST_SEARCH;
                    end
                    ST_ACTIVE:
                    begin
                        valid_q    <= 1'b1;
                        first_q    <= first_pend;
                        first_pend <= 1'b0;
                    end
                    default:
                        state <= ST_SEARCH;
                endcase
            end
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        data_q <= lane_byte_i;
    end

    assign lane_o.valid   = valid_q;
    assign lane_o.payload = data_q;
    assign lane_o.first   = first_q;
    // held byte is the final one once stop state is back
    assign lane_o.last    = valid_q & stop_state_i;

endmodule

//--- source/lane_merge.sv
//----------------------------------------------------------
// deskews two lanes by up to MAX_SKEW cycles and packs two
// byte pairs per word; a half word at burst end is dropped
//----------------------------------------------------------
`timescale 1ns/10ps

module lane_merge
    import csi2_pkg::*;
(
    input  logic          pixel_clk,
    input  logic          reset,
    csi2_stream_if.sink   lane0_i,
    csi2_stream_if.sink   lane1_i,
    csi2_stream_if.source word_o
);

    byte_t             dl0 [MAX_SKEW];
    byte_t             dl1 [MAX_SKEW];
    byte_t             tap0 [MAX_SKEW + 1];
    byte_t             tap1 [MAX_SKEW + 1];
    logic              waiting_q;
    logic              locked_q;
    logic              early0_q;
    logic [SKEW_W-1:0] skew_q;
    logic              half_q;
    logic              first_pend_q;
    logic [15:0]       lo_q;
    logic              word_valid_q;
    logic              word_first_q;
    logic              word_last_q;
    word_t             word_q;
    logic              cur_early0;
    logic [SKEW_W-1:0] cur_skew;
    logic              late_first;
    logic              late_valid;
    logic              late_last;
    logic              start_now;
    logic              pair_valid;
    logic              pair_last;
    logic              load_lo;
    byte_t             pair0;
    byte_t             pair1;

    // delay lines, either lane may be the early one
    always_ff @(posedge pixel_clk)
    begin
        dl0[0] <= lane0_i.payload;
        dl1[0] <= lane1_i.payload;
        for (int k = 1; k < MAX_SKEW; k++)
        begin
            dl0[k] <= dl0[k-1];
            dl1[k] <= dl1[k-1];
        end
    end

    always_comb
    begin
        tap0[0] = lane0_i.payload;
        tap1[0] = lane1_i.payload;
        for (int k = 1; k <= MAX_SKEW; k++)
        begin
            tap0[k] = dl0[k-1];
            tap1[k] = dl1[k-1];
        end
    end

    assign cur_early0 = (locked_q | waiting_q) & early0_q;
    assign cur_skew   = (locked_q | waiting_q) ? skew_q : '0;
    assign late_first = cur_early0 ? lane1_i.first : lane0_i.first;
    assign late_valid = cur_early0 ? lane1_i.valid : lane0_i.valid;
    assign late_last  = cur_early0 ? lane1_i.last  : lane0_i.last;

    // first pair once the late lane starts
    assign start_now  = waiting_q ? late_first
                                  : (~locked_q & lane0_i.first & lane1_i.first);
    assign pair_valid = start_now | (locked_q & late_valid);
    assign pair_last  = pair_valid & late_last;
    assign load_lo    = pair_valid & (start_now | ~half_q);
    assign pair0      = cur_early0 ? tap0[cur_skew] : lane0_i.payload;
    assign pair1      = cur_early0 ? lane1_i.payload : tap1[cur_skew];

    //----------------------------------------------------------
    // skew measure and lock
    //----------------------------------------------------------
    always_ff @(posedge pixel_clk or posedge reset)
    begin
        if (reset)
        begin
            waiting_q    <= 1'b0;
            locked_q     <= 1'b0;
            early0_q     <= 1'b0;
            skew_q       <= '0;
            half_q       <= 1'b0;
            first_pend_q <= 1'b0;
            word_valid_q <= 1'b0;
            word_first_q <= 1'b0;
            word_last_q  <= 1'b0;
        end
        else
        begin
            word_valid_q <= 1'b0;
            word_first_q <= 1'b0;
            word_last_q  <= 1'b0;
            if (waiting_q)
            begin
                if (late_first)
                begin
                    waiting_q <= 1'b0;
                    locked_q  <= ~pair_last;
                end
                else if (skew_q == SKEW_W'(MAX_SKEW))
                    waiting_q <= 1'b0;
                else
                    skew_q <= skew_q + 1'b1;
            end
            else if (locked_q)
            begin
                if (pair_last)
                    locked_q <= 1'b0;
            end
            else if (lane0_i.first & lane1_i.first)
            begin
                locked_q <= ~pair_last;
                early0_q <= 1'b0;
                skew_q   <= '0;
            end
            else if (lane0_i.first | lane1_i.first)
            begin
                waiting_q <= 1'b1;
                early0_q  <= lane0_i.first;
                skew_q    <= SKEW_W'(1);
            end

            // two pairs per word
            if (start_now)
                first_pend_q <= 1'b1;
            if (load_lo)
                half_q <= ~pair_last;
            else if (pair_valid)
            begin
                half_q       <= 1'b0;
                word_valid_q <= 1'b1;
                word_first_q <= first_pend_q;
                word_last_q  <= pair_last;
                first_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (load_lo)
            lo_q <= {pair1, pair0};
        else if (pair_valid)
            word_q <= {pair1, pair0, lo_q};
    end

    assign word_o.valid   = word_valid_q;
    assign word_o.payload = word_q;
    assign word_o.first   = word_first_q;
    assign word_o.last    = word_last_q;

endmodule

//--- source/packet_header.sv
//----------------------------------------------------------
// first word of each burst is the packet header; ECC errors
// are flagged only, never corrected
//----------------------------------------------------------
`timescale 1ns/10ps

module packet_header
    import csi2_pkg::*;
(
    input  logic          pixel_clk,
    input  logic          reset,
    csi2_stream_if.sink   word_i,
    csi2_stream_if.source payload_o,
    output logic          header_ok_o,
    output data_type_t    data_type_o,
    output logic [15:0]   word_count_o
);

    logic  hdr_in;
    logic  hdr_good;
    logic  valid_q;
    logic  first_q;
    logic  last_q;
    word_t data_q;

    assign hdr_in = word_i.valid & word_i.first;

    // received ECC against recomputed parity, spare bits zero
    assign hdr_good = (word_i.payload[29:24] == ecc_parity(word_i.payload[23:0]))
                      && (word_i.payload[31:30] == 2'b00);

    always_ff @(posedge pixel_clk or posedge reset)
    begin
        if (reset)
        begin
            valid_q     <= 1'b0;
            first_q     <= 1'b0;
            last_q      <= 1'b0;
            header_ok_o <= 1'b0;
        end
        else
        begin
            valid_q     <= word_i.valid;
            first_q     <= hdr_in;
            last_q      <= word_i.valid & word_i.last;
            header_ok_o <= hdr_in & hdr_good;
        end
    end

    //----------------------------------------------------------
    // header fields, held until the next header
    //----------------------------------------------------------
    always_ff @(posedge pixel_clk)
    begin
        data_q <= word_i.payload;
        if (hdr_in)
        begin
            data_type_o  <= word_i.payload[5:0];
            word_count_o <= word_i.payload[23:8];
        end
    end

    // first doubles as the header-valid flag
    assign payload_o.valid   = valid_q;
    assign payload_o.payload = data_q;
    assign payload_o.first   = first_q;
    assign payload_o.last    = last_q;

endmodule

//--- source/payload_unpack.sv
//----------------------------------------------------------
// RAW8 only; words past the word count (checksum, trailer)
// are dropped. outputs are strobes with no back-pressure
//----------------------------------------------------------
`timescale 1ns/10ps

module payload_unpack
    import csi2_pkg::*;
(
    input  logic        pixel_clk,
    input  logic        reset,
    csi2_stream_if.sink payload_i,
    input  logic        header_ok_i,
    input  data_type_t  data_type_i,
    input  logic [15:0] word_count_i,
    output logic        word_valid_o,
    output word_t       word_data_o,
    output logic        frame_start_o,
    output logic        frame_end_o,
    output logic        ecc_error_o
);

    logic        hdr;
    logic        body;
    logic        raw8_ok;
    logic [13:0] words_left;

    assign hdr     = payload_i.valid & payload_i.first;
    assign body    = payload_i.valid & ~payload_i.first;
    assign raw8_ok = header_ok_i && (data_type_i == DT_RAW8);

    always_ff @(posedge pixel_clk or posedge reset)
    begin
        if (reset)
        begin
            word_valid_o  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            ecc_error_o   <= 1'b0;
            words_left    <= '0;
        end
        else
        begin
            word_valid_o  <= body && (words_left != '0);
            ecc_error_o   <= hdr & ~header_ok_i;
            frame_start_o <= hdr && header_ok_i && (data_type_i == DT_FRAME_START);
            frame_end_o   <= hdr && header_ok_i && (data_type_i == DT_FRAME_END);

            // count in 32-bit words
            if (hdr)
                words_left <= raw8_ok ? word_count_i[15:2] : '0;
            else if (body)
            begin
                if (payload_i.last)
                    words_left <= '0;
                else if (words_left != '0)
                    words_left <= words_left - 1'b1;
            end
        end
    end

    always_ff @(posedge pixel_clk)
    begin
        if (body)
            word_data_o <= payload_i.payload;
    end

endmodule

//--- source/csi2_rx.sv
//----------------------------------------------------------
// two-lane CSI-2 packet layer, all in pixel_clk
// lane bytes must already be deserialized and byte-clocked
//----------------------------------------------------------
`timescale 1ns/10ps

module csi2_rx
    import csi2_pkg::*;
(
    input  logic       pixel_clk,
    input  logic       reset,
    input  logic       lp_dp_i,
    input  logic       lp_dn_i,
    input  byte_t      lane0_byte_i,
    input  byte_t      lane1_byte_i,
    output logic       word_valid_o,
    output word_t      word_data_o,
    output logic       frame_start_o,
    output logic       frame_end_o,
    output logic       ecc_error_o
);

    logic        stop_state;
    logic        header_ok;
    data_type_t  data_type;
    logic [15:0] word_count;

    csi2_stream_if #(.payload_t(byte_t)) lane0_if ();
    csi2_stream_if #(.payload_t(byte_t)) lane1_if ();
    csi2_stream_if #(.payload_t(word_t)) word_if ();
    csi2_stream_if #(.payload_t(word_t)) payload_if ();

    // LP-11 on the pair means stop state
    assign stop_state = lp_dp_i & lp_dn_i;

    lane_sync u_lane_sync0 (
        .pixel_clk    (pixel_clk),
        .reset        (reset),
        .stop_state_i (stop_state),
        .lane_byte_i  (lane0_byte_i),
        .lane_o       (lane0_if)
    );

    lane_sync u_lane_sync1 (
        .pixel_clk    (pixel_clk),
        .reset        (reset),
        .stop_state_i (stop_state),
        .lane_byte_i  (lane1_byte_i),
        .lane_o       (lane1_if)
    );

    lane_merge u_lane_merge (
        .pixel_clk (pixel_clk),
        .reset     (reset),
        .lane0_i   (lane0_if),
        .lane1_i   (lane1_if),
        .word_o    (word_if)
    );

    packet_header u_packet_header (
        .pixel_clk    (pixel_clk),
        .reset        (reset),
        .word_i       (word_if),
        .payload_o    (payload_if),
        .header_ok_o  (header_ok),
        .data_type_o  (data_type),
        .word_count_o (word_count)
    );

    payload_unpack u_payload_unpack (
        .pixel_clk     (pixel_clk),
        .reset         (reset),
        .payload_i     (payload_if),
        .header_ok_i   (header_ok),
        .data_type_i   (data_type),
        .word_count_i  (word_count),
        .word_valid_o  (word_valid_o),
        .word_data_o   (word_data_o),
        .frame_start_o (frame_start_o),
        .frame_end_o   (frame_end_o),
        .ecc_error_o   (ecc_error_o)
    );

endmodule

//--- test/tb_csi2_rx.sv
//----------------------------------------------------------
// one burst per table entry, lane 1 delayed by up to
// MAX_SKEW cycles; short packets carry no checksum bytes
//----------------------------------------------------------
`timescale 1ns/10ps

module tb_csi2_rx
    import csi2_pkg::*;
();

    localparam int    HALF_PERIOD     = 2;
    localparam int    CLK_PERIOD      = 2 * HALF_PERIOD;
    localparam int    RESET_CYCLES    = 4;
    localparam int    NUM_TESTS       = 8;
    localparam int    CYCLES_PER_TEST = 200;
    localparam int    WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;
    localparam int    RESULT_WAIT     = 30;
    localparam int    SETTLE_CYCLES   = 8;
    localparam byte_t IDLE_BYTE       = 8'h00;

    typedef struct {
        data_type_t dt;
        int         wc;
        bit         bad_ecc;
        int         skew;
        bit         reuse;
    } entry_t;

    // data type, word count (frame number for short), bad ECC, lane 1 skew, reuse payload
    entry_t tests [NUM_TESTS] = '{
        '{DT_FRAME_START, 1,  1'b0, 0, 1'b0},
        '{DT_RAW8,        16, 1'b0, 0, 1'b0},
        '{DT_RAW8,        16, 1'b0, 1, 1'b1},
        '{DT_RAW8,        16, 1'b0, 2, 1'b1},
        '{DT_RAW8,        8,  1'b1, 1, 1'b0},
        '{DT_FRAME_START, 2,  1'b1, 1, 1'b0},
        '{6'h2B,          8,  1'b0, 0, 1'b0},
        '{DT_FRAME_END,   1,  1'b0, 2, 1'b0}
    };

    logic  pixel_clk;
    logic  reset;
    logic  lp_dp;
    logic  lp_dn;
    byte_t lane0_byte;
    byte_t lane1_byte;
    logic  word_valid;
    word_t word_data;
    logic  frame_start;
    logic  frame_end;
    logic  ecc_error;

    word_t rx_words [$];
    int    fs_total = 0;
    int    fe_total = 0;
    int    err_total = 0;
    byte_t payload [$];
    byte_t lane0_q [$];
    byte_t lane1_q [$];
    int    test_errors;
    int    pass_count;
    int    fail_count;

    csi2_rx u_dut (
        .pixel_clk     (pixel_clk),
        .reset         (reset),
        .lp_dp_i       (lp_dp),
        .lp_dn_i       (lp_dn),
        .lane0_byte_i  (lane0_byte),
        .lane1_byte_i  (lane1_byte),
        .word_valid_o  (word_valid),
        .word_data_o   (word_data),
        .frame_start_o (frame_start),
        .frame_end_o   (frame_end),
        .ecc_error_o   (ecc_error)
    );

    always #(HALF_PERIOD) pixel_clk = ~pixel_clk;

    // monitor for the DUT outputs
    always @(negedge pixel_clk)
    begin
        if (!reset)
        begin
            if (word_valid)
                rx_words.push_back(word_data);
            if (frame_start)
                fs_total++;
            if (frame_end)
                fe_total++;
            if (ecc_error)
                err_total++;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

    //----------------------------------------------------------
    // stimulus
    //----------------------------------------------------------
    task automatic build_lanes(input entry_t e);
        logic [23:0] hdr;
        logic [5:0]  ecc;
        logic        is_long;
        byte_t       stream [$];
        hdr     = {16'(e.wc), 2'b00, e.dt};
        ecc     = ecc_parity(hdr);
        is_long = (e.dt >= 6'h10);
        if (e.bad_ecc)
            ecc = ecc ^ 6'h01;
        stream = '{hdr[7:0], hdr[15:8], hdr[23:16], {2'b00, ecc}};
        if (is_long)
        begin
            if (!e.reuse)
            begin
                payload.delete();
                for (int i = 0; i < e.wc; i++)
                    payload.push_back(8'($urandom));
            end
            foreach (payload[i])
                stream.push_back(payload[i]);
            // checksum is ignored by the DUT
            stream.push_back(8'($urandom));
            stream.push_back(8'($urandom));
        end
        lane0_q.delete();
        lane1_q.delete();
        foreach (stream[k])
        begin
            if (k % 2 == 0)
                lane0_q.push_back(stream[k]);
            else
                lane1_q.push_back(stream[k]);
        end
    endtask

    task automatic send_burst(input int skew);
        int len;
        len = lane0_q.size();
        lp_dp      = 1'b1;
        lp_dn      = 1'b1;
        lane0_byte = IDLE_BYTE;
        lane1_byte = IDLE_BYTE;
        repeat (4) @(negedge pixel_clk);
        lp_dp = 1'b0;
        lp_dn = 1'b0;
        repeat (2) @(negedge pixel_clk);
        for (int c = 0; c <= len + skew; c++)
        begin
            if (c == 0)
                lane0_byte = SYNC_BYTE;
            else if (c <= len)
                lane0_byte = lane0_q[c-1];
            else
                lane0_byte = IDLE_BYTE;
            if (c < skew)
                lane1_byte = IDLE_BYTE;
            else if (c == skew)
                lane1_byte = SYNC_BYTE;
            else
                lane1_byte = lane1_q[c-skew-1];
            @(negedge pixel_clk);
        end
        lp_dp      = 1'b1;
        lp_dn      = 1'b1;
        lane0_byte = IDLE_BYTE;
        lane1_byte = IDLE_BYTE;
    endtask

    //----------------------------------------------------------
    // checks
    //----------------------------------------------------------
    function automatic int strobe_total();
        return fs_total + fe_total + err_total;
    endfunction

    task automatic wait_results(input int word_base, input int exp_words,
                                input int strobe_base, input int exp_strobes);
        int waited;
        waited = 0;
        while (((rx_words.size() - word_base) < exp_words ||
                (strobe_total() - strobe_base) < exp_strobes) && waited < RESULT_WAIT)
        begin
            @(negedge pixel_clk);
            waited++;
        end
        if ((rx_words.size() - word_base) < exp_words ||
            (strobe_total() - strobe_base) < exp_strobes)
        begin
            $display("timed out waiting for the DUT to deliver the packet results");
            test_errors++;
        end
        // catch anything extra
        repeat (SETTLE_CYCLES) @(negedge pixel_clk);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input int idx);
        if (got !== exp)
        begin
            $display("Error: word_data_o[%0d] got 0x%08h expected 0x%08h", idx, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("Error: %s count got 0x%0h expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic run_test(input int n);
        entry_t e;
        int     exp_words;
        int     exp_fs;
        int     exp_fe;
        int     exp_err;
        int     word_base;
        int     fs_base;
        int     fe_base;
        int     err_base;
        int     got_words;
        e           = tests[n];
        test_errors = 0;
        exp_fs      = (!e.bad_ecc && e.dt == DT_FRAME_START) ? 1 : 0;
        exp_fe      = (!e.bad_ecc && e.dt == DT_FRAME_END) ? 1 : 0;
        exp_err     = e.bad_ecc ? 1 : 0;
        exp_words   = (!e.bad_ecc && e.dt == DT_RAW8) ? e.wc / 4 : 0;
        build_lanes(e);
        word_base = rx_words.size();
        fs_base   = fs_total;
        fe_base   = fe_total;
        err_base  = err_total;
        send_burst(e.skew);
        wait_results(word_base, exp_words, fs_base + fe_base + err_base,
                     exp_fs + exp_fe + exp_err);
        got_words = rx_words.size() - word_base;
        check_count("word_valid_o", got_words, exp_words);
        // payload byte 0 lands in the low byte
        for (int i = 0; i < exp_words && i < got_words; i++)
            check_word(rx_words[word_base + i],
                       {payload[4*i+3], payload[4*i+2], payload[4*i+1], payload[4*i]}, i);
        check_count("frame_start_o", fs_total - fs_base, exp_fs);
        check_count("frame_end_o", fe_total - fe_base, exp_fe);
        check_count("ecc_error_o", err_total - err_base, exp_err);
        if (test_errors == 0)
            pass_count++;
        else
            fail_count++;
        $display("test %0d dt 0x%02h wc %0d skew %0d bad_ecc %0d: %s", n, e.dt, e.wc,
                 e.skew, e.bad_ecc, (test_errors == 0) ? "ok" : "FAILED");
    endtask

    initial
    begin
        pixel_clk  = 1'b0;
        reset      = 1'b1;
        lp_dp      = 1'b1;
        lp_dn      = 1'b1;
        lane0_byte = IDLE_BYTE;
        lane1_byte = IDLE_BYTE;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(36));
        repeat (RESET_CYCLES) @(negedge pixel_clk);
        reset = 1'b0;
        for (int n = 0; n < NUM_TESTS; n++)
            run_test(n);
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- list.f
source/csi2_pkg.sv
source/csi2_stream_if.sv
source/lane_sync.sv
source/lane_merge.sv
source/packet_header.sv
source/payload_unpack.sv
source/csi2_rx.sv
test/tb_csi2_rx.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f list.f --top-module tb_csi2_rx
	@out="$$(./obj_dir/Vtb_csi2_rx)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
